// ==== Makefile ====
# Verilator build and run for the Wishbone memory subsystem

VERILATOR ?= verilator
TOP       ?= wb_mem_subsys_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/wb_mem_subsys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_mem_subsys_tb;

    localparam int QUEUE_DEPTH  = 8;
    localparam int SAME_DELAY   = 2;
    localparam int SWITCH_DELAY = 5;
    localparam int MEM_WORDS    = wb_mem_pkg::MEM_WORDS;
    localparam int SEL_W        = wb_mem_pkg::SEL_W;
    // 8 + 12 + 12 + 20 + 30 requests over the five tests
    localparam int TOTAL_REQS   = 82;
    localparam int LIMIT_CYCLES = MEM_WORDS + TOTAL_REQS * (SWITCH_DELAY + 3) + 200;

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 cyc_i;
    logic                 stb_i;
    logic                 we_i;
    wb_mem_pkg::wb_addr_t addr_i;
    wb_mem_pkg::wb_sel_t  sel_i;
    wb_mem_pkg::wb_data_t wdata_i;
    wb_mem_pkg::wb_data_t rdata_o;
    logic                 ack_o;
    logic                 stall_o;

    // reference memory and expected responses in acceptance order
    wb_mem_pkg::wb_data_t model_mem [MEM_WORDS];
    wb_mem_pkg::wb_data_t exp_data_q [$];
    logic                 exp_we_q [$];
    wb_mem_pkg::wb_addr_t test_addrs [$];
    wb_mem_pkg::wb_data_t cmp_data;
    logic                 cmp_we;

    logic [31:0] rng_state = 32'h5606;
    logic        stall_seen = 1'b0;
    int          acc_cnt = 0;
    int          ack_cnt = 0;
    int          errors = 0;
    int          err_mark = 0;
    int          pass_tests = 0;
    int          fail_tests = 0;

    wb_mem_subsys #(
        .QUEUE_DEPTH  (QUEUE_DEPTH),
        .SAME_DELAY   (SAME_DELAY),
        .SWITCH_DELAY (SWITCH_DELAY)
    ) wb_mem_subsys_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .cyc_i   (cyc_i),
        .stb_i   (stb_i),
        .we_i    (we_i),
        .addr_i  (addr_i),
        .sel_i   (sel_i),
        .wdata_i (wdata_i),
        .rdata_o (rdata_o),
        .ack_o   (ack_o),
        .stall_o (stall_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // expected word after a byte-masked write
    function automatic wb_mem_pkg::wb_data_t merge_bytes(
        input wb_mem_pkg::wb_data_t old_word,
        input wb_mem_pkg::wb_data_t new_word,
        input wb_mem_pkg::wb_sel_t  sel
    );
        wb_mem_pkg::wb_data_t res;
        res = old_word;
        for (int i = 0; i < SEL_W; i++) begin
            if (sel[i]) begin
                res[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_data(input string name, input wb_mem_pkg::wb_data_t exp,
                              input wb_mem_pkg::wb_data_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    // entered just after a rising edge, returns on the edge that accepts
    task automatic send(input logic we, input wb_mem_pkg::wb_addr_t addr,
                        input wb_mem_pkg::wb_sel_t sel, input wb_mem_pkg::wb_data_t wdata);
        cyc_i   <= 1'b1;
        stb_i   <= 1'b1;
        we_i    <= we;
        addr_i  <= addr;
        sel_i   <= sel;
        wdata_i <= wdata;
        @(negedge clk_i);
        while (stall_o) begin
            stall_seen = 1'b1;
            @(negedge clk_i);
        end
        // taken on the coming edge, so the model follows bus order
        if (we) begin
            model_mem[addr] = merge_bytes(model_mem[addr], wdata, sel);
            exp_data_q.push_back('0);
        end else begin
            exp_data_q.push_back(model_mem[addr]);
        end
        exp_we_q.push_back(we);
        acc_cnt++;
        @(posedge clk_i);
    endtask

    task automatic end_burst();
        cyc_i <= 1'b0;
        stb_i <= 1'b0;
        we_i  <= 1'b0;
    endtask

    task automatic finish_test(input string name);
        while (ack_cnt != acc_cnt) begin
            @(posedge clk_i);
        end
        // stray acks after the drain would show up here
        repeat (SWITCH_DELAY + 3) @(posedge clk_i);
        check_count("ack_o count", acc_cnt, ack_cnt);
        if (errors == err_mark) begin
            pass_tests++;
            $display("%s: ok", name);
        end else begin
            fail_tests++;
            $display("%s: %0d error(s)", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // compare process, one expected entry per ack
    always @(negedge clk_i) begin
        if (rst_n_i && ack_o) begin
            ack_cnt++;
            if (exp_we_q.size() == 0) begin
                report_error("ack_o pulsed with no request outstanding");
            end else begin
                cmp_we   = exp_we_q.pop_front();
                cmp_data = exp_data_q.pop_front();
                if (cmp_we) begin
                    // write acks carry zero data
                    check_data("rdata_o on write ack", '0, rdata_o);
                end else begin
                    check_data("rdata_o", cmp_data, rdata_o);
                end
            end
        end else if (rst_n_i) begin
            // no read data outside an ack cycle
            check_data("rdata_o without ack", '0, rdata_o);
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk_i);
        $display("timeout after %0d cycles, %0d of %0d acks seen", LIMIT_CYCLES, ack_cnt, acc_cnt);
        $display("test failed");
        $finish;
    end

    initial begin
        int                   clear_cycles;
        logic [31:0]          r;
        logic                 is_wr;
        wb_mem_pkg::wb_addr_t a;
        wb_mem_pkg::wb_addr_t last_wr;
        rst_n_i = 1'b0;
        cyc_i   = 1'b0;
        stb_i   = 1'b0;
        we_i    = 1'b0;
        addr_i  = '0;
        sel_i   = '0;
        wdata_i = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[wb_mem_pkg::wb_addr_t'(i)] = '0;
        end
        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // 1: clear sweep holds stall, then unwritten words read zero
        clear_cycles = 0;
        @(negedge clk_i);
        while (stall_o) begin
            clear_cycles++;
            if (ack_o) begin
                report_error("ack_o pulsed during the clear sweep");
            end
            @(negedge clk_i);
        end
        check_count("clear cycles", MEM_WORDS, clear_cycles);
        @(posedge clk_i);
        for (int i = 0; i < 8; i++) begin
            send(1'b0, wb_mem_pkg::wb_addr_t'(next_rand()), '1, '0);
        end
        end_burst();
        finish_test("reset and clear");

        // 2: full-mask writes then read back
        for (int i = 0; i < 6; i++) begin
            test_addrs.push_back(wb_mem_pkg::wb_addr_t'(next_rand()));
            send(1'b1, test_addrs[i], '1, {next_rand(), next_rand()});
        end
        for (int i = 0; i < 6; i++) begin
            send(1'b0, test_addrs[i], '1, '0);
        end
        end_burst();
        finish_test("full-mask writes");

        // 3: partial masks over the words written above
        for (int i = 0; i < 6; i++) begin
            send(1'b1, test_addrs[i], wb_mem_pkg::wb_sel_t'(next_rand()),
                 {next_rand(), next_rand()});
        end
        for (int i = 0; i < 6; i++) begin
            send(1'b0, test_addrs[i], '1, '0);
        end
        end_burst();
        finish_test("byte-mask merge");

        // 4: burst longer than the queue
        stall_seen = 1'b0;
        for (int i = 0; i < 20; i++) begin
            r = next_rand();
            send(r[0], wb_mem_pkg::wb_addr_t'(r >> 8), wb_mem_pkg::wb_sel_t'(r >> 20),
                 {next_rand(), next_rand()});
        end
        end_burst();
        if (!stall_seen) begin
            report_error("stall_o never rose during the long burst");
        end
        finish_test("back-pressure burst");

        // 5: mixed bursts over a small address range, cyc dropped between them
        for (int b = 0; b < 3; b++) begin
            for (int i = 0; i < 10; i++) begin
                r = next_rand();
                a = wb_mem_pkg::wb_addr_t'(r[7:3]);
                if (i % 4 == 3) begin
                    send(1'b0, last_wr, '1, '0);
                end else begin
                    // the request before each read-back is always a write
                    is_wr = r[0] || (i % 4 == 2);
                    if (is_wr) begin
                        last_wr = a;
                    end
                    send(is_wr, a, wb_mem_pkg::wb_sel_t'(r >> 12), {next_rand(), next_rand()});
                end
            end
            end_burst();
            repeat (3) @(posedge clk_i);
        end
        finish_test("random mix");

        $display("tests: %0d ok, %0d with errors, %0d check errors",
                 pass_tests, fail_tests, errors);
        if (fail_tests == 0 && errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : wb_mem_subsys_tb

`default_nettype wire

// ==== hw/wb_mem_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_mem_array (
    input  wire                   clk_i,
    input  wire                   we_i,
    input  wb_mem_pkg::wb_addr_t  addr_i,
    input  wb_mem_pkg::wb_sel_t   sel_i,
    input  wb_mem_pkg::wb_data_t  wdata_i,
    input  wire                   re_i,
    output wb_mem_pkg::wb_data_t  rd_data_o
);

    localparam int SEL_W     = wb_mem_pkg::SEL_W;
    localparam int MEM_WORDS = wb_mem_pkg::MEM_WORDS;

    wb_mem_pkg::wb_data_t mem [MEM_WORDS];

    // byte-lane write port
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int i = 0; i < SEL_W; i++) begin
                if (sel_i[i]) begin
                    mem[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
                end
            end
        end
    end

    // registered read, data is valid the cycle after re_i
    always_ff @(posedge clk_i) begin
        if (re_i) begin
            rd_data_o <= mem[addr_i];
        end
    end

endmodule : wb_mem_array

`default_nettype wire

// ==== hw/wb_mem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_mem_ctrl #(
    parameter int SAME_DELAY   = 2,
    parameter int SWITCH_DELAY = 5
) (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  wb_mem_pkg::wb_req_t   head_i,
    input  wire                   valid_i,
    input  wb_mem_pkg::wb_data_t  rd_data_i,
    output logic                  pop_o,
    output logic                  clearing_o,
    output logic                  mem_we_o,
    output logic                  mem_re_o,
    output wb_mem_pkg::wb_addr_t  mem_addr_o,
    output wb_mem_pkg::wb_sel_t   mem_sel_o,
    output wb_mem_pkg::wb_data_t  mem_wdata_o,
    output logic                  ack_o,
    output wb_mem_pkg::wb_data_t  rdata_o
);

    localparam int MAX_DELAY = (SWITCH_DELAY > SAME_DELAY) ? SWITCH_DELAY : SAME_DELAY;
    localparam int DLY_W     = $clog2(MAX_DELAY + 1);

    wb_mem_pkg::ctrl_state_t state_q;
    wb_mem_pkg::ctrl_state_t state_d;

    wb_mem_pkg::wb_addr_t clr_addr_q;
    logic [DLY_W-1:0]     dly_cnt_q;
    logic                 last_we_q;
    logic                 last_valid_q;
    logic                 wr_ack_q;
    logic                 service;
    logic [DLY_W-1:0]     dly_load;

    // first request after reset always counts as a switch
    assign dly_load = (last_valid_q && (head_i.we == last_we_q)) ?
                      DLY_W'(SAME_DELAY) : DLY_W'(SWITCH_DELAY);

    assign service    = (state_q == wb_mem_pkg::ST_WAIT) && (dly_cnt_q == '0) && valid_i;
    assign clearing_o = (state_q == wb_mem_pkg::ST_CLEAR);
    assign pop_o      = service;

    always_comb begin
        state_d = state_q;
        case (state_q)
            wb_mem_pkg::ST_CLEAR: begin
                if (clr_addr_q == '1) begin
                    state_d = wb_mem_pkg::ST_IDLE;
                end
            end
            wb_mem_pkg::ST_IDLE: begin
                if (valid_i) begin
                    state_d = wb_mem_pkg::ST_WAIT;
                end
            end
            wb_mem_pkg::ST_WAIT: begin
                if (service) begin
                    state_d = head_i.we ? wb_mem_pkg::ST_IDLE : wb_mem_pkg::ST_READ;
                end
            end
            default: state_d = wb_mem_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= wb_mem_pkg::ST_CLEAR;
            clr_addr_q   <= '0;
            dly_cnt_q    <= '0;
            last_we_q    <= 1'b0;
            last_valid_q <= 1'b0;
            wr_ack_q     <= 1'b0;
        end else begin
            state_q  <= state_d;
            wr_ack_q <= service && head_i.we;
            if (clearing_o) begin
                clr_addr_q <= clr_addr_q + 1'b1;
            end
            if ((state_q == wb_mem_pkg::ST_IDLE) && valid_i) begin
                dly_cnt_q <= dly_load;
            end else if ((state_q == wb_mem_pkg::ST_WAIT) && (dly_cnt_q != '0)) begin
                dly_cnt_q <= dly_cnt_q - 1'b1;
            end
            if (service) begin
                last_we_q    <= head_i.we;
                last_valid_q <= 1'b1;
            end
        end
    end

    // the clear sweep owns the write port until it finishes
    assign mem_we_o    = clearing_o || (service && head_i.we);
    assign mem_re_o    = service && !head_i.we;
    assign mem_addr_o  = clearing_o ? clr_addr_q : head_i.addr;
    assign mem_sel_o   = clearing_o ? '1 : head_i.sel;
    assign mem_wdata_o = clearing_o ? '0 : head_i.wdata;

    // write acks trail the array update, read acks carry the array output
    assign ack_o   = wr_ack_q || (state_q == wb_mem_pkg::ST_READ);
    assign rdata_o = (state_q == wb_mem_pkg::ST_READ) ? rd_data_i : '0;

endmodule : wb_mem_ctrl

`default_nettype wire

// ==== hw/wb_mem_pkg.sv ====
`default_nettype none

package wb_mem_pkg;

    // bus geometry
    localparam int DATA_W    = 64;
    localparam int ADDR_W    = 10;
    localparam int SEL_W     = DATA_W / 8;
    localparam int MEM_WORDS = 2 ** ADDR_W;

    typedef logic [DATA_W-1:0] wb_data_t;
    typedef logic [ADDR_W-1:0] wb_addr_t;
    typedef logic [SEL_W-1:0]  wb_sel_t;

    // one accepted request as held in the queue
    typedef struct packed {
        logic     we;
        wb_addr_t addr;
        wb_sel_t  sel;
        wb_data_t wdata;
    } wb_req_t;

    // controller states
    typedef enum logic [1:0] {
        ST_CLEAR,
        ST_IDLE,
        ST_WAIT,
        ST_READ
    } ctrl_state_t;

endpackage : wb_mem_pkg

`default_nettype wire

// ==== hw/wb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_mem_subsys #(
    parameter int QUEUE_DEPTH  = 8,
    parameter int SAME_DELAY   = 2,
    parameter int SWITCH_DELAY = 5
) (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  wire                   cyc_i,
    input  wire                   stb_i,
    input  wire                   we_i,
    input  wb_mem_pkg::wb_addr_t  addr_i,
    input  wb_mem_pkg::wb_sel_t   sel_i,
    input  wb_mem_pkg::wb_data_t  wdata_i,
    output wb_mem_pkg::wb_data_t  rdata_o,
    output logic                  ack_o,
    output logic                  stall_o
);

    wb_mem_pkg::wb_req_t  bus_req;
    wb_mem_pkg::wb_req_t  head;
    wb_mem_pkg::wb_addr_t mem_addr;
    wb_mem_pkg::wb_sel_t  mem_sel;
    wb_mem_pkg::wb_data_t mem_wdata;
    wb_mem_pkg::wb_data_t mem_rd_data;

    logic accept;
    logic q_valid;
    logic q_full;
    logic pop;
    logic clearing;
    logic mem_we;
    logic mem_re;

    // pipelined handshake, one request per unstalled strobe
    assign accept  = cyc_i && stb_i && !stall_o;
    assign stall_o = clearing || q_full;

    assign bus_req = '{we: we_i, addr: addr_i, sel: sel_i, wdata: wdata_i};

    wb_req_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) wb_req_queue_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .push_i  (accept),
        .req_i   (bus_req),
        .pop_i   (pop),
        .head_o  (head),
        .valid_o (q_valid),
        .full_o  (q_full)
    );

    wb_mem_ctrl #(
        .SAME_DELAY   (SAME_DELAY),
        .SWITCH_DELAY (SWITCH_DELAY)
    ) wb_mem_ctrl_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .head_i      (head),
        .valid_i     (q_valid),
        .rd_data_i   (mem_rd_data),
        .pop_o       (pop),
        .clearing_o  (clearing),
        .mem_we_o    (mem_we),
        .mem_re_o    (mem_re),
        .mem_addr_o  (mem_addr),
        .mem_sel_o   (mem_sel),
        .mem_wdata_o (mem_wdata),
        .ack_o       (ack_o),
        .rdata_o     (rdata_o)
    );

    wb_mem_array wb_mem_array_inst (
        .clk_i     (clk_i),
        .we_i      (mem_we),
        .addr_i    (mem_addr),
        .sel_i     (mem_sel),
        .wdata_i   (mem_wdata),
        .re_i      (mem_re),
        .rd_data_o (mem_rd_data)
    );

endmodule : wb_mem_subsys

`default_nettype wire

// ==== hw/wb_req_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_req_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  wire                  clk_i,
    input  wire                  rst_n_i,
    input  wire                  push_i,
    input  wb_mem_pkg::wb_req_t  req_i,
    input  wire                  pop_i,
    output wb_mem_pkg::wb_req_t  head_o,
    output logic                 valid_o,
    output logic                 full_o
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    wb_mem_pkg::wb_req_t slots [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_push;
    logic do_pop;

    // never overrun or underrun, even if the caller misbehaves
    assign do_push = push_i && (count != CNT_W'(QUEUE_DEPTH));
    assign do_pop  = pop_i && (count != '0);

    // payload storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            slots[wr_ptr] <= req_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                // explicit wrap so non power-of-two depths work
                if (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_o  = slots[rd_ptr];
    assign valid_o = (count != '0);

    // one slot of margin for the request taken in the cycle stall rises
    assign full_o = (count >= CNT_W'(QUEUE_DEPTH - 1));

endmodule : wb_req_queue

`default_nettype wire

// ==== src.f ====
hw/wb_mem_pkg.sv
hw/wb_req_queue.sv
hw/wb_mem_array.sv
hw/wb_mem_ctrl.sv
hw/wb_mem_subsys.sv
dv/wb_mem_subsys_tb.sv
